// File: common/cluster_periph_pkg.sv
//**************************************************
// peripheral bus has no back-pressure, valid is a one-cycle strobe
// slots come from addr[11:10], offsets within a slot from addr[9:0]
//**************************************************

package cluster_periph_pkg;

  //**************************************************
  // widths
  //**************************************************
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  evt_data_t;
  typedef logic [4:0]  irq_id_t;
  typedef logic [1:0]  slot_t;
  typedef logic [9:0]  ofs_t;

  //**************************************************
  // bus structs
  //**************************************************
  // request, 66 bits
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
  } per_req_t;

  // response, 33 bits
  typedef struct packed {
    logic  r_valid;
    data_t r_rdata;
  } per_rsp_t;

  //**************************************************
  // address map
  //**************************************************
  // slots 2 and 3 are unmapped
  localparam slot_t SLOT_CTRL  = 2'd0;
  localparam slot_t SLOT_TIMER = 2'd1;

  // read data of an unmapped slot
  localparam data_t ERR_RDATA = 32'hDEAD_B33F;

  // control unit, boot address of core i at CTRL_BOOT_OFS + 4*i
  localparam ofs_t CTRL_EOC_OFS   = 10'h000;
  localparam ofs_t CTRL_FETCH_OFS = 10'h008;
  localparam ofs_t CTRL_BOOT_OFS  = 10'h040;

  // timer
  localparam ofs_t TIMER_CFG_OFS = 10'h000;
  localparam ofs_t TIMER_CNT_OFS = 10'h004;
  localparam ofs_t TIMER_CMP_OFS = 10'h008;

  // interrupt ids seen by the cores
  localparam irq_id_t TIMER_IRQ_ID   = 5'd10;
  localparam irq_id_t SOC_EVT_IRQ_ID = 5'd27;

endpackage

// File: hdl/periph_bus_demux.sv
//**************************************************
// read data is sampled in the request cycle, r_valid follows one cycle later
// writes to unmapped slots are dropped
//**************************************************
`timescale 1ns/100ps

module periph_bus_demux (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  cluster_periph_pkg::per_req_t  per_req_i,
  input  cluster_periph_pkg::data_t     ctrl_rdata_i,
  input  cluster_periph_pkg::data_t     tmr_rdata_i,
  output cluster_periph_pkg::per_rsp_t  per_rsp_o,
  output cluster_periph_pkg::per_req_t  ctrl_req_o,
  output cluster_periph_pkg::per_req_t  tmr_req_o
);

  cluster_periph_pkg::slot_t slot;
  cluster_periph_pkg::data_t rdata_sel;
  logic                      r_valid_q;
  cluster_periph_pkg::data_t r_rdata_q;

  assign slot = per_req_i.addr[11:10];

  // strobe goes to one block at most
  always_comb begin
    ctrl_req_o       = per_req_i;
    tmr_req_o        = per_req_i;
    ctrl_req_o.valid = per_req_i.valid && (slot == cluster_periph_pkg::SLOT_CTRL);
    tmr_req_o.valid  = per_req_i.valid && (slot == cluster_periph_pkg::SLOT_TIMER);
  end

  // pick the data of the addressed slot
  always_comb begin
    case (slot)
      cluster_periph_pkg::SLOT_CTRL:  rdata_sel = ctrl_rdata_i;
      cluster_periph_pkg::SLOT_TIMER: rdata_sel = tmr_rdata_i;
      default:                        rdata_sel = cluster_periph_pkg::ERR_RDATA;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= per_req_i.valid;
    end
  end

  // response payload, only loaded on a request
  always_ff @(posedge clk_i) begin
    if (per_req_i.valid) begin
      r_rdata_q <= rdata_sel;
    end
  end

  assign per_rsp_o.r_valid = r_valid_q;
  assign per_rsp_o.r_rdata = r_rdata_q;

endmodule

// File: ctrl_unit/cluster_ctrl_unit.sv
//**************************************************
// NB_CORES must be a power of two from 2 to 16
// fetch_en_i forces fetch enable on every core
//**************************************************
`timescale 1ns/100ps

module cluster_ctrl_unit #(
  parameter int unsigned               NB_CORES      = 8,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR     = 32'h1C00_0000,
  parameter cluster_periph_pkg::addr_t ROM_BOOT_ADDR = 32'h1A00_0000
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  cluster_periph_pkg::per_req_t               req_i,
  input  logic                                       fetch_en_i,
  input  logic                                       en_sa_boot_i,
  output cluster_periph_pkg::data_t                  rdata_o,
  output logic                                       eoc_o,
  output logic [NB_CORES-1:0]                        fetch_en_o,
  output cluster_periph_pkg::addr_t [NB_CORES-1:0]   boot_addr_o
);

  localparam int unsigned IDX_W = $clog2(NB_CORES);

  cluster_periph_pkg::ofs_t                ofs;
  cluster_periph_pkg::ofs_t                ofs_rel;
  logic                                    boot_hit;
  logic [IDX_W-1:0]                        boot_idx;
  logic                                    wr;
  logic                                    eoc_q;
  logic [NB_CORES-1:0]                     fetch_mask_q;
  cluster_periph_pkg::addr_t [NB_CORES-1:0] boot_addr_q;

  //**************************************************
  // offset decode
  //**************************************************
  assign ofs      = req_i.addr[9:0];
  assign ofs_rel  = ofs - cluster_periph_pkg::CTRL_BOOT_OFS;
  assign boot_idx = ofs_rel[IDX_W+1:2];
  assign boot_hit = (ofs >= cluster_periph_pkg::CTRL_BOOT_OFS) &&
                    (ofs_rel < 4 * NB_CORES) && (ofs[1:0] == 2'b00);
  assign wr       = req_i.valid && req_i.we;

  //**************************************************
  // registers
  //**************************************************
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      eoc_q        <= 1'b0;
      fetch_mask_q <= '0;
      for (int i = 0; i < NB_CORES; i++) begin
        boot_addr_q[i] <= BOOT_ADDR;
      end
    end else if (wr) begin
      if (ofs == cluster_periph_pkg::CTRL_EOC_OFS) begin
        eoc_q <= req_i.wdata[0];
      end
      if (ofs == cluster_periph_pkg::CTRL_FETCH_OFS) begin
        fetch_mask_q <= req_i.wdata[NB_CORES-1:0];
      end
      if (boot_hit) begin
        boot_addr_q[boot_idx] <= req_i.wdata;
      end
    end
  end

  // read back, unknown offsets give zero
  always_comb begin
    rdata_o = '0;
    if (ofs == cluster_periph_pkg::CTRL_EOC_OFS) begin
      rdata_o[0] = eoc_q;
    end else if (ofs == cluster_periph_pkg::CTRL_FETCH_OFS) begin
      rdata_o[NB_CORES-1:0] = fetch_mask_q;
    end else if (boot_hit) begin
      rdata_o = boot_addr_q[boot_idx];
    end
  end

  //**************************************************
  // outputs
  //**************************************************
  assign eoc_o      = eoc_q;
  assign fetch_en_o = fetch_mask_q | {NB_CORES{fetch_en_i}};

  // standalone boot starts every core from ROM
  always_comb begin
    for (int i = 0; i < NB_CORES; i++) begin
      boot_addr_o[i] = en_sa_boot_i ? ROM_BOOT_ADDR : boot_addr_q[i];
    end
  end

endmodule

// File: timer/cluster_timer.sv
//**************************************************
// single 32-bit counter on clk_i, no prescaler
// a COUNT write wins over the increment in the same cycle
//**************************************************
`timescale 1ns/100ps

module cluster_timer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  cluster_periph_pkg::per_req_t req_i,
  output cluster_periph_pkg::data_t    rdata_o,
  output logic                         irq_o,
  output logic                         busy_o
);

  cluster_periph_pkg::ofs_t  ofs;
  logic                      wr;
  logic                      en_q;
  logic                      clr_q;
  cluster_periph_pkg::data_t cnt_q;
  cluster_periph_pkg::data_t cmp_q;
  logic                      match;
  logic                      irq_q;

  assign ofs   = req_i.addr[9:0];
  assign wr    = req_i.valid && req_i.we;
  assign match = en_q && (cnt_q == cmp_q);

  //**************************************************
  // config and compare
  //**************************************************
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      en_q  <= 1'b0;
      clr_q <= 1'b0;
      cmp_q <= '0;
    end else if (wr) begin
      if (ofs == cluster_periph_pkg::TIMER_CFG_OFS) begin
        en_q  <= req_i.wdata[0];
        clr_q <= req_i.wdata[1];
      end
      if (ofs == cluster_periph_pkg::TIMER_CMP_OFS) begin
        cmp_q <= req_i.wdata;
      end
    end
  end

  //**************************************************
  // counter and match strobe
  //**************************************************
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      irq_q <= 1'b0;
    end else begin
      irq_q <= match;
      if (wr && (ofs == cluster_periph_pkg::TIMER_CNT_OFS)) begin
        cnt_q <= req_i.wdata;
      end else if (match && clr_q) begin
        cnt_q <= '0;
      end else if (en_q) begin
        cnt_q <= cnt_q + 32'd1;
      end
    end
  end

  always_comb begin
    case (ofs)
      cluster_periph_pkg::TIMER_CFG_OFS: rdata_o = {30'd0, clr_q, en_q};
      cluster_periph_pkg::TIMER_CNT_OFS: rdata_o = cnt_q;
      cluster_periph_pkg::TIMER_CMP_OFS: rdata_o = cmp_q;
      default:                           rdata_o = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign busy_o = en_q;

endmodule

// File: hdl/core_event_gate.sv
//**************************************************
// SoC event payload low bits select the target core
// first-fetch flags only clear on reset
//**************************************************
`timescale 1ns/100ps

module core_event_gate #(
  parameter int unsigned NB_CORES = 8
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic [NB_CORES-1:0]                        fetch_en_i,
  input  logic                                       tmr_irq_i,
  input  logic                                       soc_evt_valid_i,
  input  cluster_periph_pkg::evt_data_t              soc_evt_data_i,
  input  logic                                       isolate_i,
  input  logic [NB_CORES-1:0]                        core_busy_i,
  input  logic [NB_CORES-1:0]                        irq_ack_i,
  output logic                                       soc_evt_ready_o,
  output logic [NB_CORES-1:0]                        irq_req_o,
  output cluster_periph_pkg::irq_id_t [NB_CORES-1:0] irq_id_o,
  output logic [NB_CORES-1:0]                        core_clk_en_o,
  output logic [NB_CORES-1:0]                        fetch_enable_o
);

  localparam int unsigned IDX_W = $clog2(NB_CORES);

  logic                soc_acc;
  logic [IDX_W-1:0]    soc_tgt;
  logic [NB_CORES-1:0] pend_tmr_q;
  logic [NB_CORES-1:0] pend_soc_q;
  logic [NB_CORES-1:0] first_fetch_q;
  logic [NB_CORES-1:0] first_fetch_qq;

  // isolation blocks the SoC event path
  assign soc_evt_ready_o = ~isolate_i;
  assign soc_acc         = soc_evt_valid_i && !isolate_i;
  assign soc_tgt         = soc_evt_data_i[IDX_W-1:0];

  for (genvar i = 0; i < NB_CORES; i++) begin : g_core

    //**************************************************
    // pending events
    //**************************************************
    // ack retires the event whose id is shown, new events win
    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        pend_tmr_q[i] <= 1'b0;
        pend_soc_q[i] <= 1'b0;
      end else begin
        if (tmr_irq_i) begin
          pend_tmr_q[i] <= 1'b1;
        end else if (irq_ack_i[i] && pend_tmr_q[i]) begin
          pend_tmr_q[i] <= 1'b0;
        end
        if (soc_acc && (soc_tgt == IDX_W'(i))) begin
          pend_soc_q[i] <= 1'b1;
        end else if (irq_ack_i[i] && !pend_tmr_q[i]) begin
          pend_soc_q[i] <= 1'b0;
        end
      end
    end

    assign irq_req_o[i] = pend_tmr_q[i] | pend_soc_q[i];
    assign irq_id_o[i]  = pend_tmr_q[i] ? cluster_periph_pkg::TIMER_IRQ_ID
                                        : cluster_periph_pkg::SOC_EVT_IRQ_ID;

    //**************************************************
    // first-fetch gating
    //**************************************************
    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        first_fetch_q[i]  <= 1'b0;
        first_fetch_qq[i] <= 1'b0;
      end else begin
        first_fetch_qq[i] <= first_fetch_q[i];
        if (fetch_en_i[i]) begin
          first_fetch_q[i] <= 1'b1;
        end
      end
    end

    // clock runs while busy or while an event waits
    assign core_clk_en_o[i]  = first_fetch_q[i] & (core_busy_i[i] | irq_req_o[i]);
    assign fetch_enable_o[i] = first_fetch_qq[i] & fetch_en_i[i];

  end

endmodule

// File: hdl/cluster_periph_top.sv
//**************************************************
// one peripheral bus port, control unit in slot 0, timer in slot 1
//**************************************************
`timescale 1ns/100ps

module cluster_periph_top #(
  parameter int unsigned               NB_CORES      = 8,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR     = 32'h1C00_0000,
  parameter cluster_periph_pkg::addr_t ROM_BOOT_ADDR = 32'h1A00_0000
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  cluster_periph_pkg::per_req_t               per_req_i,
  output cluster_periph_pkg::per_rsp_t               per_rsp_o,
  input  logic                                       fetch_en_i,
  input  logic                                       en_sa_boot_i,
  input  logic                                       isolate_i,
  input  logic [NB_CORES-1:0]                        core_busy_i,
  input  logic [NB_CORES-1:0]                        irq_ack_i,
  input  logic                                       soc_evt_valid_i,
  input  cluster_periph_pkg::evt_data_t              soc_evt_data_i,
  output logic                                       soc_evt_ready_o,
  output logic                                       eoc_o,
  output logic                                       busy_o,
  output cluster_periph_pkg::addr_t [NB_CORES-1:0]   boot_addr_o,
  output logic [NB_CORES-1:0]                        fetch_enable_o,
  output logic [NB_CORES-1:0]                        core_clk_en_o,
  output logic [NB_CORES-1:0]                        irq_req_o,
  output cluster_periph_pkg::irq_id_t [NB_CORES-1:0] irq_id_o
);

  cluster_periph_pkg::per_req_t ctrl_req;
  cluster_periph_pkg::per_req_t tmr_req;
  cluster_periph_pkg::data_t    ctrl_rdata;
  cluster_periph_pkg::data_t    tmr_rdata;
  logic [NB_CORES-1:0]          fetch_en;
  logic                         tmr_irq;

  periph_bus_demux u_demux (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .per_req_i    ( per_req_i  ),
    .ctrl_rdata_i ( ctrl_rdata ),
    .tmr_rdata_i  ( tmr_rdata  ),
    .per_rsp_o    ( per_rsp_o  ),
    .ctrl_req_o   ( ctrl_req   ),
    .tmr_req_o    ( tmr_req    )
  );

  cluster_ctrl_unit #(
    .NB_CORES      ( NB_CORES      ),
    .BOOT_ADDR     ( BOOT_ADDR     ),
    .ROM_BOOT_ADDR ( ROM_BOOT_ADDR )
  ) u_ctrl_unit (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( ctrl_req     ),
    .fetch_en_i   ( fetch_en_i   ),
    .en_sa_boot_i ( en_sa_boot_i ),
    .rdata_o      ( ctrl_rdata   ),
    .eoc_o        ( eoc_o        ),
    .fetch_en_o   ( fetch_en     ),
    .boot_addr_o  ( boot_addr_o  )
  );

  cluster_timer u_timer (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .req_i   ( tmr_req   ),
    .rdata_o ( tmr_rdata ),
    .irq_o   ( tmr_irq   ),
    .busy_o  ( busy_o    )
  );

  core_event_gate #(
    .NB_CORES ( NB_CORES )
  ) u_event_gate (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .fetch_en_i      ( fetch_en        ),
    .tmr_irq_i       ( tmr_irq         ),
    .soc_evt_valid_i ( soc_evt_valid_i ),
    .soc_evt_data_i  ( soc_evt_data_i  ),
    .isolate_i       ( isolate_i       ),
    .core_busy_i     ( core_busy_i     ),
    .irq_ack_i       ( irq_ack_i       ),
    .soc_evt_ready_o ( soc_evt_ready_o ),
    .irq_req_o       ( irq_req_o       ),
    .irq_id_o        ( irq_id_o        ),
    .core_clk_en_o   ( core_clk_en_o   ),
    .fetch_enable_o  ( fetch_enable_o  )
  );

endmodule

// File: dv/tb_cluster_periph_tasks.svh
//**************************************************
// included inside tb_cluster_periph, uses its signals and counters
//**************************************************
`ifndef TB_CLUSTER_PERIPH_TASKS_SVH
`define TB_CLUSTER_PERIPH_TASKS_SVH

// next drive point, 2 ns after the rising edge
task automatic step_cycle();
  @(posedge clk);
  #2;
endtask

task automatic flag_error(input string msg);
  err_cnt++;
  $display("ERROR at %0t ns: %s", $time, msg);
endtask

//**************************************************
// compare tasks
//**************************************************
task automatic check_data(input string name, input data_t got, input data_t exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("FAIL %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_id(input string name, input irq_id_t got, input irq_id_t exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("FAIL %s got %h expected %h", name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("FAIL %s got %h expected %h", name, got, exp);
  end
endtask

// one request, the response must come exactly one cycle after the strobe
task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                          output data_t rdata);
  per_req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
  @(negedge clk);
  if (per_rsp.r_valid !== 1'b0) begin
    flag_error("r_valid was already high in the strobe cycle");
  end
  step_cycle();
  per_req.valid = 1'b0;
  @(negedge clk);
  if (per_rsp.r_valid !== 1'b1) begin
    flag_error("r_valid did not arrive one cycle after the strobe");
  end
  rdata = per_rsp.r_rdata;
  step_cycle();
endtask

`endif

// File: dv/tb_cluster_periph.sv
//**************************************************
// runs with NB_CORES fixed at 8
// inputs change 2 ns after the rising edge and outputs are sampled on the falling edge
//**************************************************
`timescale 1ns/100ps

module tb_cluster_periph;

  localparam int unsigned NB_CORES   = 8;
  localparam int          CLK_PERIOD = 40;
  localparam int          NUM_ROWS   = 22;

  typedef cluster_periph_pkg::addr_t     addr_t;
  typedef cluster_periph_pkg::data_t     data_t;
  typedef cluster_periph_pkg::irq_id_t   irq_id_t;
  typedef cluster_periph_pkg::evt_data_t evt_data_t;

  localparam addr_t   BOOT_ADDR     = 32'h1C00_0000;
  localparam addr_t   ROM_BOOT_ADDR = 32'h1A00_0000;
  localparam irq_id_t TIMER_ID      = 5'd10;
  localparam irq_id_t SOC_ID        = 5'd27;

  //**************************************************
  // stimulus table
  //**************************************************
  typedef logic [2:0] kind_t;
  localparam kind_t KIND_BUS      = 3'd0;
  localparam kind_t KIND_RESET    = 3'd1;
  localparam kind_t KIND_EOC      = 3'd2;
  localparam kind_t KIND_BOOT_RND = 3'd3;
  localparam kind_t KIND_SA_BOOT  = 3'd4;
  localparam kind_t KIND_FETCH    = 3'd5;
  localparam kind_t KIND_TIMER    = 3'd6;
  localparam kind_t KIND_SOC      = 3'd7;

  // for SoC rows we selects isolation and wdata holds the payload
  typedef struct packed {
    kind_t kind;
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t exp;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{KIND_RESET,    1'b0, 32'h000, 32'h0000_0000, 32'h0000_0000},
    '{KIND_BUS,      1'b0, 32'h040, 32'h0000_0000, BOOT_ADDR},
    '{KIND_BUS,      1'b0, 32'h05C, 32'h0000_0000, BOOT_ADDR},
    '{KIND_BUS,      1'b0, 32'h800, 32'h0000_0000, 32'hDEAD_B33F},
    '{KIND_BUS,      1'b1, 32'h840, 32'h1234_5678, 32'h0000_0000},
    '{KIND_BUS,      1'b1, 32'hC00, 32'h0000_0001, 32'h0000_0000},
    '{KIND_BUS,      1'b0, 32'h040, 32'h0000_0000, BOOT_ADDR},
    '{KIND_BUS,      1'b0, 32'h000, 32'h0000_0000, 32'h0000_0000},
    '{KIND_BUS,      1'b0, 32'hC40, 32'h0000_0000, 32'hDEAD_B33F},
    '{KIND_BUS,      1'b1, 32'h000, 32'h0000_0001, 32'h0000_0000},
    '{KIND_EOC,      1'b0, 32'h000, 32'h0000_0000, 32'h0000_0001},
    '{KIND_BUS,      1'b0, 32'h000, 32'h0000_0000, 32'h0000_0001},
    '{KIND_BOOT_RND, 1'b0, 32'h040, 32'h0000_0000, 32'h0000_0000},
    '{KIND_SA_BOOT,  1'b0, 32'h000, 32'h0000_0000, ROM_BOOT_ADDR},
    '{KIND_FETCH,    1'b1, 32'h008, 32'h0000_000F, 32'h0000_000F},
    '{KIND_BUS,      1'b0, 32'h008, 32'h0000_0000, 32'h0000_000F},
    '{KIND_TIMER,    1'b1, 32'h400, 32'h0000_0005, 32'h0000_00FF},
    '{KIND_TIMER,    1'b1, 32'h400, 32'h0000_000C, 32'h0000_00FF},
    '{KIND_BUS,      1'b0, 32'h408, 32'h0000_0000, 32'h0000_000C},
    '{KIND_BUS,      1'b0, 32'h400, 32'h0000_0000, 32'h0000_0000},
    '{KIND_SOC,      1'b0, 32'h000, 32'h0000_0035, 32'h0000_0020},
    '{KIND_SOC,      1'b1, 32'h000, 32'h0000_0002, 32'h0000_0000}
  };

  logic                                       clk;
  logic                                       rst_n;
  cluster_periph_pkg::per_req_t               per_req;
  cluster_periph_pkg::per_rsp_t               per_rsp;
  logic                                       fetch_en;
  logic                                       en_sa_boot;
  logic                                       isolate;
  logic [NB_CORES-1:0]                        core_busy;
  logic [NB_CORES-1:0]                        irq_ack;
  logic                                       soc_evt_valid;
  evt_data_t                                  soc_evt_data;
  logic                                       soc_evt_ready;
  logic                                       eoc;
  logic                                       busy;
  addr_t [NB_CORES-1:0]                       boot_addr;
  logic [NB_CORES-1:0]                        fetch_enable;
  logic [NB_CORES-1:0]                        core_clk_en;
  logic [NB_CORES-1:0]                        irq_req;
  irq_id_t [NB_CORES-1:0]                     irq_id;

  int          err_cnt   = 0;
  int          check_cnt = 0;
  int          rows_pass = 0;
  int          rows_fail = 0;
  logic [31:0] lfsr_q;
  data_t       boot_ref [NB_CORES];
  data_t       fetch_ref;

  `include "tb_cluster_periph_tasks.svh"

  cluster_periph_top #(
    .NB_CORES      ( NB_CORES      ),
    .BOOT_ADDR     ( BOOT_ADDR     ),
    .ROM_BOOT_ADDR ( ROM_BOOT_ADDR )
  ) u_dut (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .per_req_i       ( per_req       ),
    .per_rsp_o       ( per_rsp       ),
    .fetch_en_i      ( fetch_en      ),
    .en_sa_boot_i    ( en_sa_boot    ),
    .isolate_i       ( isolate       ),
    .core_busy_i     ( core_busy     ),
    .irq_ack_i       ( irq_ack       ),
    .soc_evt_valid_i ( soc_evt_valid ),
    .soc_evt_data_i  ( soc_evt_data  ),
    .soc_evt_ready_o ( soc_evt_ready ),
    .eoc_o           ( eoc           ),
    .busy_o          ( busy          ),
    .boot_addr_o     ( boot_addr     ),
    .fetch_enable_o  ( fetch_enable  ),
    .core_clk_en_o   ( core_clk_en   ),
    .irq_req_o       ( irq_req       ),
    .irq_id_o        ( irq_id        )
  );

  initial begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  // watchdog allows 64 cycles per table row
  initial begin
    #(NUM_ROWS * 64 * CLK_PERIOD);
    $display("watchdog expired before all table rows had finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  //**************************************************
  // random data
  //**************************************************
  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic data_t rand_word();
    data_t w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  //**************************************************
  // row tasks
  //**************************************************
  task automatic check_reset_state();
    @(negedge clk);
    check_bit("eoc_o", eoc, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("r_valid", per_rsp.r_valid, 1'b0);
    check_data("irq_req_o", 32'(irq_req), '0);
    check_data("core_clk_en_o", 32'(core_clk_en), '0);
    check_data("fetch_enable_o", 32'(fetch_enable), '0);
    step_cycle();
  endtask

  task automatic check_boot_random();
    data_t rd;
    for (int i = 0; i < NB_CORES; i++) begin
      boot_ref[i] = rand_word();
      bus_access(1'b1, 32'h040 + 32'(4 * i), boot_ref[i], rd);
    end
    for (int i = 0; i < NB_CORES; i++) begin
      bus_access(1'b0, 32'h040 + 32'(4 * i), '0, rd);
      check_data("r_rdata", rd, boot_ref[i]);
    end
  endtask

  task automatic check_sa_boot(input data_t exp);
    en_sa_boot = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NB_CORES; i++) begin
      check_data("boot_addr_o", boot_addr[i], exp);
    end
    step_cycle();
    en_sa_boot = 1'b0;
    @(negedge clk);
    for (int i = 0; i < NB_CORES; i++) begin
      check_data("boot_addr_o", boot_addr[i], boot_ref[i]);
    end
    step_cycle();
  endtask

  // clock enable one cycle after the mask write lands and fetch enable one more
  task automatic check_fetch(input addr_t addr, input data_t mask, input data_t exp);
    data_t rd;
    core_busy = '1;
    fetch_ref = fetch_ref | mask;
    bus_access(1'b1, addr, mask, rd);
    @(negedge clk);
    check_data("core_clk_en_o", 32'(core_clk_en), exp);
    check_data("fetch_enable_o", 32'(fetch_enable), '0);
    step_cycle();
    @(negedge clk);
    check_data("fetch_enable_o", 32'(fetch_enable), exp);
    step_cycle();
  endtask

  task automatic ack_irqs(input data_t mask, input irq_id_t id);
    irq_ack = mask[NB_CORES-1:0];
    @(negedge clk);
    check_data("irq_req_o", 32'(irq_req), mask);
    for (int i = 0; i < NB_CORES; i++) begin
      if (mask[i]) begin
        check_id("irq_id_o", irq_id[i], id);
      end
    end
    step_cycle();
    irq_ack = '0;
    @(negedge clk);
    check_data("irq_req_o", 32'(irq_req), '0);
    step_cycle();
  endtask

  // CMP = n and count from zero, then enable with clear on match
  task automatic check_timer(input addr_t base, input data_t n, input data_t exp_mask);
    data_t rd;
    int    cyc;
    core_busy = '0;
    bus_access(1'b1, base + 32'h8, n, rd);
    bus_access(1'b1, base + 32'h4, '0, rd);
    bus_access(1'b1, base, 32'h3, rd);
    // one edge has passed since the enable landed
    cyc = 1;
    @(negedge clk);
    while ((irq_req == '0) && (cyc < int'(n) + 8)) begin
      step_cycle();
      @(negedge clk);
      cyc++;
    end
    if (irq_req == '0) begin
      flag_error("timer interrupt never reached the cores");
    end else begin
      check_data("irq_req_o latency", 32'(cyc), n + 32'd2);
      check_data("irq_req_o", 32'(irq_req), exp_mask);
      // idle cores keep their clock while the interrupt waits
      check_data("core_clk_en_o", 32'(core_clk_en), fetch_ref & exp_mask);
      check_bit("busy_o", busy, 1'b1);
    end
    step_cycle();
    bus_access(1'b1, base, '0, rd);
    // count restarted from zero at the match and ran three more edges until the disable
    bus_access(1'b0, base + 32'h4, '0, rd);
    check_data("r_rdata", rd, 32'd3);
    ack_irqs(exp_mask, TIMER_ID);
  endtask

  task automatic check_soc(input logic iso, input evt_data_t payload, input data_t exp_mask);
    isolate       = iso;
    soc_evt_valid = 1'b1;
    soc_evt_data  = payload;
    @(negedge clk);
    check_bit("soc_evt_ready_o", soc_evt_ready, !iso);
    step_cycle();
    soc_evt_valid = 1'b0;
    @(negedge clk);
    if ((exp_mask != '0) && (irq_req == '0)) begin
      flag_error("SoC event raised no interrupt");
    end
    check_data("irq_req_o", 32'(irq_req), exp_mask);
    step_cycle();
    isolate = 1'b0;
    if (exp_mask != '0) begin
      ack_irqs(exp_mask, SOC_ID);
    end
  endtask

  task automatic run_row(input row_t row);
    data_t rd;
    case (row.kind)
      KIND_BUS: begin
        bus_access(row.we, row.addr, row.wdata, rd);
        if (!row.we) begin
          check_data("r_rdata", rd, row.exp);
        end
      end
      KIND_RESET:    check_reset_state();
      KIND_EOC: begin
        @(negedge clk);
        check_bit("eoc_o", eoc, row.exp[0]);
        step_cycle();
      end
      KIND_BOOT_RND: check_boot_random();
      KIND_SA_BOOT:  check_sa_boot(row.exp);
      KIND_FETCH:    check_fetch(row.addr, row.wdata, row.exp);
      KIND_TIMER:    check_timer(row.addr, row.wdata, row.exp);
      KIND_SOC:      check_soc(row.we, row.wdata[7:0], row.exp);
      default:       flag_error("unknown row kind in the stimulus table");
    endcase
  endtask

  //**************************************************
  // main sequence
  //**************************************************
  initial begin
    int errs_before;
    per_req       = '0;
    fetch_en      = 1'b0;
    en_sa_boot    = 1'b0;
    isolate       = 1'b0;
    core_busy     = '0;
    irq_ack       = '0;
    soc_evt_valid = 1'b0;
    soc_evt_data  = '0;
    rst_n         = 1'b0;
    lfsr_q        = 32'd79290;
    fetch_ref     = '0;
    for (int i = 0; i < NB_CORES; i++) begin
      boot_ref[i] = BOOT_ADDR;
    end
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      errs_before = err_cnt;
      run_row(rows[r]);
      if (err_cnt == errs_before) begin
        rows_pass++;
        $display("row %0d kind %0d passed", r, rows[r].kind);
      end else begin
        rows_fail++;
        $display("row %0d kind %0d failed", r, rows[r].kind);
      end
    end

    $display("rows passed %0d, rows failed %0d, checks %0d, errors %0d",
             rows_pass, rows_fail, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: cluster_periph_top.f
+incdir+dv
common/cluster_periph_pkg.sv
hdl/periph_bus_demux.sv
ctrl_unit/cluster_ctrl_unit.sv
timer/cluster_timer.sv
hdl/core_event_gate.sv
hdl/cluster_periph_top.sv
dv/tb_cluster_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_cluster_periph \
  -f cluster_periph_top.f -o tb_cluster_periph > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_cluster_periph > sim.log 2>&1 \
  || echo "simulator returned an error status"
cat sim.log

grep -qx "TESTBENCH PASSED" sim.log && echo "result: pass" && exit 0 \
  || { echo "result: fail"; exit 1; }
